// File: Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = tb_autotest
FLIST   = flist.f
OBJDIR  = obj_dir
BIN     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJDIR)

// File: dv/autotest_checker.sv
// autotest port checker
`timescale 1ns/1ns
module autotest_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    spi_rst_i,
  input  logic                    spi_r_block_i,
  input  logic                    spi_r_byte_i,
  input  autotest_pkg::blk_addr_t spi_block_addr_i,
  input  logic                    uut_rst_i,
  input  autotest_pkg::word_t     uut_a_i,
  input  autotest_pkg::word_t     uut_b_i,
  input  autotest_pkg::err_cnt_t  error_count_i,
  input  logic                    done_i,
  input  autotest_pkg::word_t     exp_a_i,
  input  autotest_pkg::word_t     exp_b_i,
  input  int                      exp_reads_i,
  input  int                      exp_errors_i,
  output int                      errors_o
);

  int errors = 0;
  int reads = 0;
  logic rst_prev = 1'b0;
  logic block_prev = 1'b0;

  assign errors_o = errors;

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s expected %0h actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic fail(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  // samples at the rising edge, where every port has settled
  always @(posedge clk) begin
    if (rst) begin
      if (rst_prev) begin
        compare("reset spi_rst_o", 32'h0, 32'(spi_rst_i));
        compare("reset spi_r_block_o", 32'h0, 32'(spi_r_block_i));
        compare("reset spi_r_byte_o", 32'h0, 32'(spi_r_byte_i));
        compare("reset done_o", 32'h0, 32'(done_i));
        compare("reset uut_rst_o", 32'h1, 32'(uut_rst_i));
        compare("reset error_count_o", 32'h0, 32'(error_count_i));
      end
      reads = 0;
    end else begin
      if (spi_r_block_i && !block_prev) begin
        compare("block address", autotest_pkg::INITIAL_BLOCK + reads, spi_block_addr_i);
        reads++;
      end
      if (!uut_rst_i) begin
        compare("operand a", exp_a_i, uut_a_i);
        compare("operand b", exp_b_i, uut_b_i);
        // the last block read holds the bad signature
        if (reads >= exp_reads_i) begin
          fail("UUT was released for a block with a bad signature");
        end
      end
      if (done_i) begin
        compare("block reads", exp_reads_i, reads);
        compare("error count", exp_errors_i, 32'(error_count_i));
        reads = 0;
      end
    end
    rst_prev = rst;
    block_prev = spi_r_block_i;
  end

endmodule

// File: dv/tb_autotest.sv
// autotest testbench
`timescale 1ns/1ns
module tb_autotest;

  localparam int NUM_ROWS = 10;
  localparam int NUM_RUNS = 2;
  localparam int MAX_BLOCKS = 8;
  localparam int DONE_LIMIT = 200000;
  localparam autotest_pkg::word_t SIG = autotest_pkg::SIGNATURE;

  typedef enum logic [1:0] {
    MODE_NORMAL,
    MODE_WRONG,
    MODE_ERROR,
    MODE_HANG
  } uut_mode_t;

  typedef struct packed {
    int                  run;
    autotest_pkg::word_t sig;
    autotest_pkg::word_t a;
    autotest_pkg::word_t b;
    autotest_pkg::word_t expected;
    uut_mode_t           mode;
  } row_t;

  // one row per block and a bad signature closing each run
  row_t rows [NUM_ROWS] = '{
    '{0, SIG, 32'h0000_0003, 32'h0000_0004, 32'h0000_0007, MODE_NORMAL},
    '{0, SIG, 32'h1234_5678, 32'h1111_1111, 32'h2345_6789, MODE_WRONG},
    '{0, SIG, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, MODE_NORMAL},
    '{0, SIG, 32'h0a0b_0c0d, 32'h0101_0101, 32'h0b0c_0d0e, MODE_ERROR},
    '{0, SIG, 32'h8000_0000, 32'h8000_0000, 32'h0000_0000, MODE_HANG},
    '{0, SIG, 32'hdead_0000, 32'h0000_beef, 32'hdead_beef, MODE_NORMAL},
    '{0, 32'h0bad_5160, 32'h0, 32'h0, 32'h0, MODE_NORMAL},
    '{1, SIG, 32'h0000_0010, 32'h0000_0020, 32'h0000_0030, MODE_NORMAL},
    '{1, SIG, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, MODE_NORMAL},
    '{1, 32'haabb_ccdc, 32'h0, 32'h0, 32'h0, MODE_NORMAL}
  };

  logic clk = 1'b0;
  logic rst;
  logic start;
  logic spi_busy;
  autotest_pkg::byte_t spi_data;
  logic spi_err;
  logic spi_rst_o;
  logic spi_r_block_o;
  logic spi_r_byte_o;
  autotest_pkg::blk_addr_t spi_block_addr_o;
  logic uut_rst_o;
  autotest_pkg::word_t uut_a_o;
  autotest_pkg::word_t uut_b_o;
  autotest_pkg::word_t uut_result;
  logic uut_end;
  logic uut_err;
  autotest_pkg::err_cnt_t error_count_o;
  logic done_o;

  autotest_pkg::byte_t image [MAX_BLOCKS * autotest_pkg::BLOCK_BYTES];
  logic [31:0] fill_lfsr = 32'h5b00;
  logic [31:0] host_lfsr = 32'h5b00;
  logic [31:0] uut_lfsr = 32'h5b00;
  int cur_row = 0;
  int row_base = 0;
  int exp_reads = 0;
  int exp_errors = 0;
  int timeouts = 0;
  int check_errors;

  always #50 clk = ~clk;

  autotest_top autotest_top_i (
    .clk              (clk),
    .rst              (rst),
    .start_i          (start),
    .spi_busy_i       (spi_busy),
    .spi_data_i       (spi_data),
    .spi_err_i        (spi_err),
    .spi_rst_o        (spi_rst_o),
    .spi_r_block_o    (spi_r_block_o),
    .spi_r_byte_o     (spi_r_byte_o),
    .spi_block_addr_o (spi_block_addr_o),
    .uut_rst_o        (uut_rst_o),
    .uut_a_o          (uut_a_o),
    .uut_b_o          (uut_b_o),
    .uut_result_i     (uut_result),
    .uut_end_i        (uut_end),
    .uut_err_i        (uut_err),
    .error_count_o    (error_count_o),
    .done_o           (done_o)
  );

  autotest_checker checker_i (
    .clk              (clk),
    .rst              (rst),
    .spi_rst_i        (spi_rst_o),
    .spi_r_block_i    (spi_r_block_o),
    .spi_r_byte_i     (spi_r_byte_o),
    .spi_block_addr_i (spi_block_addr_o),
    .uut_rst_i        (uut_rst_o),
    .uut_a_i          (uut_a_o),
    .uut_b_i          (uut_b_o),
    .error_count_i    (error_count_o),
    .done_i           (done_o),
    .exp_a_i          (rows[cur_row].a),
    .exp_b_i          (rows[cur_row].b),
    .exp_reads_i      (exp_reads),
    .exp_errors_i     (exp_errors),
    .errors_o         (check_errors)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      value = {value[30:0], state[0]};
    end
  endtask

  task automatic place_vector(input int blk, input row_t row);
    int base;
    base = blk * autotest_pkg::BLOCK_BYTES;
    for (int k = 0; k < 4; k++) begin
      image[base + k] = row.sig[31 - 8 * k -: 8];
      image[base + autotest_pkg::OFS_A + k] = row.a[8 * k +: 8];
      image[base + autotest_pkg::OFS_B + k] = row.b[8 * k +: 8];
      image[base + autotest_pkg::OFS_EXP + k] = row.expected[8 * k +: 8];
    end
  endtask

  task automatic load_run(input int run);
    logic [31:0] fill;
    for (int i = 0; i < MAX_BLOCKS * autotest_pkg::BLOCK_BYTES; i++) begin
      take_bits(fill_lfsr, 8, fill);
      image[i] = fill[7:0];
    end
    exp_reads = 0;
    exp_errors = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].run == run) begin
        if (exp_reads == 0) begin
          row_base = r;
        end
        place_vector(exp_reads, rows[r]);
        if (rows[r].sig == SIG && rows[r].mode != MODE_NORMAL) begin
          exp_errors++;
        end
        exp_reads++;
      end
    end
  endtask

  function automatic autotest_pkg::byte_t block_byte(input autotest_pkg::blk_addr_t addr,
                                                     input int ofs);
    int blk;
    blk = int'(addr - autotest_pkg::INITIAL_BLOCK);
    if (blk < 0 || blk >= MAX_BLOCKS) begin
      return 8'h00;
    end
    return image[blk * autotest_pkg::BLOCK_BYTES + ofs];
  endfunction

  // short random busy delays with the data set as busy falls
  task automatic busy_handshake(input autotest_pkg::byte_t data);
    logic [31:0] delay;
    take_bits(host_lfsr, 2, delay);
    repeat (delay) @(negedge clk);
    spi_busy = 1'b1;
    take_bits(host_lfsr, 2, delay);
    repeat (delay + 1) @(negedge clk);
    spi_data = data;
    spi_busy = 1'b0;
  endtask

  initial begin : sd_host
    autotest_pkg::blk_addr_t addr;
    int ofs;
    int blk;
    logic in_block;
    addr = '0;
    ofs = 0;
    in_block = 1'b0;
    forever begin
      @(negedge clk);
      if (rst) begin
        in_block = 1'b0;
      end else if (spi_rst_o) begin
        busy_handshake(spi_data);
      end else if (spi_r_block_o && !in_block) begin
        in_block = 1'b1;
        addr = spi_block_addr_o;
        ofs = 0;
        blk = int'(addr - autotest_pkg::INITIAL_BLOCK);
        if (blk >= 0 && blk < exp_reads) begin
          cur_row = row_base + blk;
        end
        busy_handshake(block_byte(addr, ofs));
      end else if (spi_r_byte_o) begin
        ofs++;
        busy_handshake(block_byte(addr, ofs));
      end else if (!spi_r_block_o) begin
        in_block = 1'b0;
      end
    end
  end

  initial begin : uut_model
    logic [31:0] delay;
    int waited;
    forever begin
      @(negedge clk);
      if (!rst && !uut_rst_o) begin
        take_bits(uut_lfsr, 6, delay);
        repeat (delay) @(negedge clk);
        case (rows[cur_row].mode)
          MODE_NORMAL: begin
            uut_result = uut_a_o + uut_b_o;
            uut_end = 1'b1;
          end
          MODE_WRONG: begin
            uut_result = uut_a_o + uut_b_o + 32'd1;
            uut_end = 1'b1;
          end
          MODE_ERROR: uut_err = 1'b1;
          default: ;
        endcase
        waited = 0;
        while (!uut_rst_o && waited < autotest_pkg::TIMEOUT_CYCLES + 16) begin
          @(negedge clk);
          waited++;
        end
        if (!uut_rst_o) begin
          $display("UUT was not put back into reset after the run limit");
          timeouts++;
        end
        uut_end = 1'b0;
        uut_err = 1'b0;
      end
    end
  end

  initial begin : stimulus
    int waited;
    logic abort;
    rst = 1'b1;
    start = 1'b0;
    spi_busy = 1'b0;
    spi_data = '0;
    spi_err = 1'b0;
    uut_result = '0;
    uut_end = 1'b0;
    uut_err = 1'b0;
    abort = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int run = 0; run < NUM_RUNS && !abort; run++) begin
      load_run(run);
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      waited = 0;
      while (!done_o && waited < DONE_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (!done_o) begin
        $display("run %0d never signalled done", run);
        timeouts++;
        abort = 1'b1;
      end
      // checker samples done at the next rising edge, keep this run's table until then
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("check errors %0d, timeouts %0d", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: flist.f
source/autotest_pkg.sv
source/sd_block_reader.sv
source/vector_loader.sv
source/test_runner.sv
source/autotest_ctrl.sv
source/autotest_top.sv
dv/autotest_checker.sv
dv/tb_autotest.sv

// File: source/autotest_ctrl.sv
// self-test sequencer fsm
`timescale 1ns/1ns
module autotest_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start_i,
  input  logic                    spi_busy_i,
  output logic                    spi_rst_o,
  output autotest_pkg::blk_addr_t spi_block_addr_o,
  output logic                    fetch_start_o,
  input  logic                    fetch_done_i,
  output logic                    clear_vector_o,
  input  autotest_pkg::word_t     signature_i,
  output logic                    run_start_o,
  input  logic                    run_done_i,
  output logic                    clear_errors_o,
  output logic                    done_o
);

  autotest_pkg::ctrl_state_t state;
  autotest_pkg::ctrl_state_t state_nxt;
  logic fetch_kick;
  logic sig_match;

  assign sig_match = (signature_i == autotest_pkg::SIGNATURE);

  // one pulse opens each fetch and wipes the old vector
  assign fetch_start_o = fetch_kick;
  assign clear_vector_o = fetch_kick;

  always_comb begin
    state_nxt = state;
    spi_rst_o = 1'b0;
    clear_errors_o = 1'b0;
    run_start_o = 1'b0;
    done_o = 1'b0;
    case (state)
      autotest_pkg::IDLE: begin
        if (start_i) begin
          clear_errors_o = 1'b1;
          state_nxt = autotest_pkg::SPI_RESET;
        end
      end
      autotest_pkg::SPI_RESET: begin
        spi_rst_o = 1'b1;
        if (spi_busy_i) begin
          state_nxt = autotest_pkg::SPI_WAIT;
        end
      end
      autotest_pkg::SPI_WAIT: begin
        if (!spi_busy_i) begin
          state_nxt = autotest_pkg::FETCH;
        end
      end
      autotest_pkg::FETCH: begin
        if (fetch_done_i) begin
          state_nxt = autotest_pkg::CHECK_SIG;
        end
      end
      autotest_pkg::CHECK_SIG: begin
        // a foreign block marks the end of the test set
        if (sig_match) begin
          run_start_o = 1'b1;
          state_nxt = autotest_pkg::RUN;
        end else begin
          state_nxt = autotest_pkg::FINISH;
        end
      end
      autotest_pkg::RUN: begin
        if (run_done_i) begin
          state_nxt = autotest_pkg::NEXT_BLOCK;
        end
      end
      autotest_pkg::NEXT_BLOCK: state_nxt = autotest_pkg::FETCH;
      autotest_pkg::FINISH: begin
        done_o = 1'b1;
        state_nxt = autotest_pkg::IDLE;
      end
      default: state_nxt = autotest_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= autotest_pkg::IDLE;
      spi_block_addr_o <= autotest_pkg::INITIAL_BLOCK;
      fetch_kick <= 1'b0;
    end else begin
      state <= state_nxt;
      fetch_kick <= (state_nxt == autotest_pkg::FETCH) && (state != autotest_pkg::FETCH);
      if (state == autotest_pkg::IDLE && start_i) begin
        spi_block_addr_o <= autotest_pkg::INITIAL_BLOCK;
      end else if (state == autotest_pkg::NEXT_BLOCK) begin
        spi_block_addr_o <= spi_block_addr_o + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(fetch_start_o && run_start_o));

  // done is a single pulse out of FINISH
  assert property (@(posedge clk) disable iff (rst)
    done_o |-> (state == autotest_pkg::FINISH) ##1 (state == autotest_pkg::IDLE && !done_o));

endmodule

// File: source/autotest_pkg.sv
// autotest shared definitions
package autotest_pkg;

  localparam int BYTE_W = 8;
  localparam int WORD_W = 32;
  localparam int BLOCK_BYTES = 512;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [31:0] blk_addr_t;
  typedef logic [$clog2(BLOCK_BYTES)-1:0] byte_ofs_t;
  typedef logic [15:0] cycle_cnt_t;
  typedef logic [15:0] err_cnt_t;

  localparam blk_addr_t INITIAL_BLOCK = 32'h100000;
  localparam word_t SIGNATURE = 32'hAABBCCDD;
  localparam int TIMEOUT_CYCLES = 2000;

  // field offsets inside a block, signature sits at 0
  localparam int OFS_A = 4;
  localparam int OFS_B = 8;
  localparam int OFS_EXP = 12;

  typedef enum logic [2:0] {
    IDLE,
    SPI_RESET,
    SPI_WAIT,
    FETCH,
    CHECK_SIG,
    RUN,
    NEXT_BLOCK,
    FINISH
  } ctrl_state_t;

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_REQ,
    RD_WAIT_BLOCK,
    RD_SAMPLE,
    RD_BYTE_REQ,
    RD_BYTE_WAIT
  } rd_state_t;

endpackage

// File: source/autotest_top.sv
// hardware self-test top
`timescale 1ns/1ns
module autotest_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start_i,
  input  logic                    spi_busy_i,
  input  autotest_pkg::byte_t     spi_data_i,
  input  logic                    spi_err_i,
  output logic                    spi_rst_o,
  output logic                    spi_r_block_o,
  output logic                    spi_r_byte_o,
  output autotest_pkg::blk_addr_t spi_block_addr_o,
  output logic                    uut_rst_o,
  output autotest_pkg::word_t     uut_a_o,
  output autotest_pkg::word_t     uut_b_o,
  input  autotest_pkg::word_t     uut_result_i,
  input  logic                    uut_end_i,
  input  logic                    uut_err_i,
  output autotest_pkg::err_cnt_t  error_count_o,
  output logic                    done_o
);

  logic fetch_start;
  logic fetch_done;
  logic clear_vector;
  logic byte_valid;
  autotest_pkg::byte_t byte_data;
  autotest_pkg::byte_ofs_t byte_ofs;
  autotest_pkg::word_t signature;
  autotest_pkg::word_t expected;
  logic run_start;
  logic run_done;
  logic clear_errors;

  // spi_err_i is not acted upon, a bad read shows up as a signature mismatch

  autotest_ctrl ctrl_i (
    .clk              (clk),
    .rst              (rst),
    .start_i          (start_i),
    .spi_busy_i       (spi_busy_i),
    .spi_rst_o        (spi_rst_o),
    .spi_block_addr_o (spi_block_addr_o),
    .fetch_start_o    (fetch_start),
    .fetch_done_i     (fetch_done),
    .clear_vector_o   (clear_vector),
    .signature_i      (signature),
    .run_start_o      (run_start),
    .run_done_i       (run_done),
    .clear_errors_o   (clear_errors),
    .done_o           (done_o)
  );

  sd_block_reader reader_i (
    .clk           (clk),
    .rst           (rst),
    .fetch_start_i (fetch_start),
    .spi_busy_i    (spi_busy_i),
    .spi_data_i    (spi_data_i),
    .spi_r_block_o (spi_r_block_o),
    .spi_r_byte_o  (spi_r_byte_o),
    .byte_valid_o  (byte_valid),
    .byte_data_o   (byte_data),
    .byte_ofs_o    (byte_ofs),
    .fetch_done_o  (fetch_done)
  );

  vector_loader loader_i (
    .clk          (clk),
    .rst          (rst),
    .clear_i      (clear_vector),
    .byte_valid_i (byte_valid),
    .byte_data_i  (byte_data),
    .byte_ofs_i   (byte_ofs),
    .signature_o  (signature),
    .operand_a_o  (uut_a_o),
    .operand_b_o  (uut_b_o),
    .expected_o   (expected)
  );

  test_runner runner_i (
    .clk            (clk),
    .rst            (rst),
    .run_start_i    (run_start),
    .clear_errors_i (clear_errors),
    .expected_i     (expected),
    .uut_rst_o      (uut_rst_o),
    .uut_result_i   (uut_result_i),
    .uut_end_i      (uut_end_i),
    .uut_err_i      (uut_err_i),
    .run_done_o     (run_done),
    .error_count_o  (error_count_o)
  );

endmodule

// File: source/sd_block_reader.sv
// sd card block reader
`timescale 1ns/1ns
module sd_block_reader (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_start_i,
  input  logic                    spi_busy_i,
  input  autotest_pkg::byte_t     spi_data_i,
  output logic                    spi_r_block_o,
  output logic                    spi_r_byte_o,
  output logic                    byte_valid_o,
  output autotest_pkg::byte_t     byte_data_o,
  output autotest_pkg::byte_ofs_t byte_ofs_o,
  output logic                    fetch_done_o
);

  autotest_pkg::rd_state_t state;
  autotest_pkg::rd_state_t state_nxt;
  autotest_pkg::byte_ofs_t ofs;
  logic last_byte;

  assign last_byte = (ofs == autotest_pkg::byte_ofs_t'(autotest_pkg::BLOCK_BYTES - 1));
  assign byte_data_o = spi_data_i;
  assign byte_ofs_o = ofs;

  always_comb begin
    state_nxt = state;
    spi_r_block_o = 1'b0;
    spi_r_byte_o = 1'b0;
    byte_valid_o = 1'b0;
    fetch_done_o = 1'b0;
    case (state)
      autotest_pkg::RD_IDLE: begin
        if (fetch_start_i) begin
          state_nxt = autotest_pkg::RD_REQ;
        end
      end
      autotest_pkg::RD_REQ: begin
        spi_r_block_o = 1'b1;
        if (spi_busy_i) begin
          state_nxt = autotest_pkg::RD_WAIT_BLOCK;
        end
      end
      autotest_pkg::RD_WAIT_BLOCK: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          state_nxt = autotest_pkg::RD_SAMPLE;
        end
      end
      autotest_pkg::RD_SAMPLE: begin
        // host data is valid here, hand it on
        spi_r_block_o = 1'b1;
        byte_valid_o = 1'b1;
        if (last_byte) begin
          fetch_done_o = 1'b1;
          state_nxt = autotest_pkg::RD_IDLE;
        end else begin
          state_nxt = autotest_pkg::RD_BYTE_REQ;
        end
      end
      autotest_pkg::RD_BYTE_REQ: begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o = 1'b1;
        if (spi_busy_i) begin
          state_nxt = autotest_pkg::RD_BYTE_WAIT;
        end
      end
      autotest_pkg::RD_BYTE_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          state_nxt = autotest_pkg::RD_SAMPLE;
        end
      end
      default: state_nxt = autotest_pkg::RD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= autotest_pkg::RD_IDLE;
      ofs <= '0;
    end else begin
      state <= state_nxt;
      // wraps back to zero after the last byte
      if (byte_valid_o) begin
        ofs <= ofs + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) spi_r_byte_o |-> spi_r_block_o);

endmodule

// File: source/test_runner.sv
// uut run and result check
`timescale 1ns/1ns
module test_runner (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run_start_i,
  input  logic                   clear_errors_i,
  input  autotest_pkg::word_t    expected_i,
  output logic                   uut_rst_o,
  input  autotest_pkg::word_t    uut_result_i,
  input  logic                   uut_end_i,
  input  logic                   uut_err_i,
  output logic                   run_done_o,
  output autotest_pkg::err_cnt_t error_count_o
);

  autotest_pkg::cycle_cnt_t cycle_cnt;
  logic running;
  logic timeout;
  logic run_end;
  logic fail;

  assign uut_rst_o = !running;
  assign timeout = (cycle_cnt == autotest_pkg::cycle_cnt_t'(autotest_pkg::TIMEOUT_CYCLES - 1));
  assign run_end = running && (uut_end_i || uut_err_i || timeout);

  // without end or err the run timed out
  assign fail = uut_err_i || !uut_end_i || (uut_result_i != expected_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      cycle_cnt <= '0;
      run_done_o <= 1'b0;
      error_count_o <= '0;
    end else begin
      run_done_o <= run_end;
      if (run_start_i) begin
        running <= 1'b1;
        cycle_cnt <= '0;
      end else if (run_end) begin
        running <= 1'b0;
      end else if (running) begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
      if (clear_errors_i) begin
        error_count_o <= '0;
      end else if (run_end && fail) begin
        error_count_o <= error_count_o + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) run_done_o |-> uut_rst_o);

endmodule

// File: source/vector_loader.sv
// test vector loader
`timescale 1ns/1ns
module vector_loader (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear_i,
  input  logic                    byte_valid_i,
  input  autotest_pkg::byte_t     byte_data_i,
  input  autotest_pkg::byte_ofs_t byte_ofs_i,
  output autotest_pkg::word_t     signature_o,
  output autotest_pkg::word_t     operand_a_o,
  output autotest_pkg::word_t     operand_b_o,
  output autotest_pkg::word_t     expected_o
);

  logic [$bits(autotest_pkg::byte_ofs_t)-3:0] word_idx;
  logic [1:0] lane;

  // every field is one aligned word
  assign word_idx = byte_ofs_i[$bits(autotest_pkg::byte_ofs_t)-1:2];
  assign lane = byte_ofs_i[1:0];

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      signature_o <= '0;
      operand_a_o <= '0;
      operand_b_o <= '0;
      expected_o <= '0;
    end else if (byte_valid_i) begin
      case (word_idx)
        // signature arrives msb first
        0: signature_o[(3 - lane) * autotest_pkg::BYTE_W +: autotest_pkg::BYTE_W] <= byte_data_i;
        autotest_pkg::OFS_A / 4: begin
          operand_a_o[lane * autotest_pkg::BYTE_W +: autotest_pkg::BYTE_W] <= byte_data_i;
        end
        autotest_pkg::OFS_B / 4: begin
          operand_b_o[lane * autotest_pkg::BYTE_W +: autotest_pkg::BYTE_W] <= byte_data_i;
        end
        autotest_pkg::OFS_EXP / 4: begin
          expected_o[lane * autotest_pkg::BYTE_W +: autotest_pkg::BYTE_W] <= byte_data_i;
        end
        default: ;
      endcase
    end
  end

endmodule
